// ==== all.f ====
+incdir+verif
design/rs_pkg.sv
design/dp_ram.sv
design/rs_bus_if.sv
design/input_syndromes.sv
design/block_transport.sv
design/out_buffer.sv
design/out_stage.sv
design/rs_check_top.sv
verif/tb_rs_check.sv

// ==== design/block_transport.sv ====
// block_transport: copies the 188 data bytes of a finished block into the fill bank
`timescale 1ns/1ps

module block_transport
	import rs_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  logic      syn_ready,	// block stored, syndromes known
	input  logic      syn_zero,
	output logic      rd_re,		// input memory read port
	output blk_addr_t rd_addr,
	input  gf_elem_t  rd_data,
	ram_wr_if.xfer    wr			// toward the output banks
);

	xfer_state_t state;
	blk_addr_t   wr_addr_q;		// read address one clock late
	logic        wr_we_q;
	logic        done_q;
	logic        zero_flag;		// syn_zero of the block in flight

	assign rd_re = (state == XFER_COPY);	// one read every clock while copying

	// write side is the read side delayed one clock
	assign wr.we         = wr_we_q;
	assign wr.addr       = wr_addr_q;
	assign wr.block_done = done_q;
	assign wr.data       = done_q ? gf_elem_t'(zero_flag) : rd_data;	// flag rides bit 0

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state     <= XFER_IDLE;
			rd_addr   <= '0;
			wr_addr_q <= '0;
			wr_we_q   <= 1'b0;
			done_q    <= 1'b0;
			zero_flag <= 1'b0;
		end
		else
		begin
			wr_we_q   <= rd_re;
			wr_addr_q <= rd_addr;
			done_q    <= wr_we_q && (wr_addr_q == blk_addr_t'(RS_K - 1));	// after last write
			case (state)
				XFER_IDLE:
				begin
					if (syn_ready)
					begin
						state     <= XFER_COPY;
						rd_addr   <= '0;
						zero_flag <= syn_zero;	// keep flag with its block
					end
				end
				XFER_COPY:
				begin
					rd_addr <= rd_addr + 1'b1;
					if (rd_addr == blk_addr_t'(RS_K - 1))
						state <= XFER_IDLE;	// 188 reads issued, parity is not copied
				end
				default: state <= XFER_IDLE;
			endcase
		end
	end

endmodule

// ==== design/dp_ram.sv ====
// dp_ram: simple dual port block memory, one write port and one registered read port
`timescale 1ns/1ps

module dp_ram
#(
	parameter int num_words  = 188,
	parameter int addr_width = 8,
	parameter int data_width = 8
)
(
	input  logic                  clk,
	input  logic                  we,		// write strobe
	input  logic [addr_width-1:0] waddr,
	input  logic [data_width-1:0] wdata,
	input  logic                  re,		// read strobe, data next clock
	input  logic [addr_width-1:0] raddr,
	output logic [data_width-1:0] rdata
);

	logic [data_width-1:0] mem [0:num_words-1];	// storage, no reset

	always_ff @(posedge clk)
	begin
		if (we)
			mem[waddr] <= wdata;
		if (re)
			rdata <= mem[raddr];	// read one clock late
	end

endmodule

// ==== design/input_syndromes.sv ====
// input_syndromes: stores incoming blocks and forms the 16 syndromes with a zero check
`timescale 1ns/1ps

module input_syndromes
	import rs_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  logic      ce,			// one clock per input byte
	input  gf_elem_t  in_byte,
	input  logic      rd_re,		// read port for the transport
	input  blk_addr_t rd_addr,
	output gf_elem_t  rd_data,
	output logic      syn_ready,	// one clock after the ce of byte 203
	output logic      syn_zero		// all syndromes zero, valid with syn_ready
);

	blk_addr_t wr_addr;						// running position in block
	gf_elem_t  syn      [RS_PARITY];		// horner accumulators
	gf_elem_t  syn_next [RS_PARITY];
	logic      all_zero;
	logic      last_byte;

	// block store, transport reads it behind the writes
	dp_ram #(.num_words(RS_N), .addr_width($bits(blk_addr_t)), .data_width($bits(gf_elem_t)))
	in_mem (
		.clk   (clk),
		.we    (ce),
		.waddr (wr_addr),
		.wdata (in_byte),
		.re    (rd_re),
		.raddr (rd_addr),
		.rdata (rd_data)
	);

	assign last_byte = (wr_addr == blk_addr_t'(RS_N - 1));

	////////////////////////////////////////
	// S_i = S_i * alpha^i + r, first byte is x^203
	always_comb
	begin
		all_zero = 1'b1;
		for (int i = 0; i < RS_PARITY; i++)
		begin
			syn_next[i] = gf_mul_alpha_pow(syn[i], syn_idx_t'(i)) ^ in_byte;
			if (syn_next[i] != '0)
				all_zero = 1'b0;	// any nonzero syndrome marks the block bad
		end
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wr_addr   <= '0;
			syn_ready <= 1'b0;
			syn_zero  <= 1'b0;
			syn       <= '{default: '0};
		end
		else
		begin
			syn_ready <= 1'b0;	// pulse
			if (ce)
			begin
				if (last_byte)
				begin
					wr_addr   <= '0;				// wrap for the next block
					syn_ready <= 1'b1;
					syn_zero  <= all_zero;
					syn       <= '{default: '0};	// fresh accumulators
				end
				else
				begin
					wr_addr <= wr_addr + 1'b1;
					syn     <= syn_next;
				end
			end
		end
	end

endmodule

// ==== design/out_buffer.sv ====
// out_buffer: ping-pong output banks with per-bank block_ok and held start toward the reader
`timescale 1ns/1ps

module out_buffer
	import rs_pkg::*;
(
	input  logic     clk,
	input  logic     reset,
	ram_wr_if.buffer wr,			// fill side from transport
	ram_rd_if.buffer rd,			// drain side to out stage
	input  logic     reader_busy	// out stage still streaming
);

	logic     fill_sel;			// bank being written
	logic     drain_sel;		// bank being read out
	logic     pend_bank;		// finished bank waiting for the reader
	logic     pending;			// a finished bank not yet started
	logic     bank_ok [2];		// syndrome flag per bank
	gf_elem_t bank_rdata [2];

	////////////////////////////////////////
	// two banks, writes go to fill, reads to drain
	for (genvar b = 0; b < 2; b++)
	begin : g_bank
		dp_ram #(.num_words(RS_K), .addr_width($bits(blk_addr_t)),
			.data_width($bits(gf_elem_t)))
		bank_mem (
			.clk   (clk),
			.we    (wr.we && (fill_sel == 1'(b))),
			.waddr (wr.addr),
			.wdata (wr.data),
			.re    (rd.re && (drain_sel == 1'(b))),
			.raddr (rd.addr),
			.rdata (bank_rdata[b])
		);
	end

	// drain_sel only moves on start, so data still matches the read that made it
	assign rd.data     = bank_rdata[drain_sel];
	assign rd.block_ok = bank_ok[drain_sel];

	// start right after block_done when reader is free, else when it frees up
	assign rd.start = pending && !reader_busy;

	////////////////////////////////////////
	// bank switching
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			fill_sel  <= 1'b0;
			drain_sel <= 1'b0;
			pend_bank <= 1'b0;
			pending   <= 1'b0;
			bank_ok   <= '{default: 1'b0};
		end
		else
		begin
			if (rd.start)
			begin
				pending   <= 1'b0;			// reader took it
				drain_sel <= pend_bank;
			end
			if (wr.block_done)
			begin
				bank_ok[fill_sel] <= wr.data[0];	// flag arrives on data bit 0
				pend_bank         <= fill_sel;
				pending           <= 1'b1;			// hold until reader is idle
				fill_sel          <= ~fill_sel;		// next block goes to the other bank
			end
		end
	end

endmodule

// ==== design/out_stage.sv ====
// out_stage: paced reader, one byte every 8 clocks with ceo, valid_out and block_ok
`timescale 1ns/1ps

module out_stage
	import rs_pkg::*;
(
	input  logic     clk,
	input  logic     reset,
	ram_rd_if.reader rd,
	output logic     busy,		// block in progress, holds off the next start
	output gf_elem_t out_byte,
	output logic     ceo,		// one clock per output byte
	output logic     valid_out,	// first ceo to clock after last ceo
	output logic     block_ok	// steady across valid_out
);

	out_state_t state;
	pace_cnt_t  pace;		// position inside the 8 clock slot
	blk_addr_t  rd_addr;
	logic       ld;			// rd.data valid this clock
	logic       ld_last;	// ... and it is byte 187
	logic       ceo_last;

	// read late in the slot so the first ceo lands 9 clocks after start
	assign rd.re   = (state == OUT_STREAM) && (pace == pace_cnt_t'(OUT_SPACING - 2));
	assign rd.addr = rd_addr;
	assign busy    = (state == OUT_STREAM) || valid_out;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state     <= OUT_IDLE;
			pace      <= '0;
			rd_addr   <= '0;
			ld        <= 1'b0;
			ld_last   <= 1'b0;
			ceo       <= 1'b0;
			ceo_last  <= 1'b0;
			valid_out <= 1'b0;
			block_ok  <= 1'b0;
		end
		else
		begin
			ld       <= rd.re;
			ld_last  <= rd.re && (rd_addr == blk_addr_t'(RS_K - 1));
			ceo      <= ld;
			ceo_last <= ld && ld_last;
			if (ld && !valid_out)
				block_ok <= rd.block_ok;	// taken once per block
			if (ld)
				valid_out <= 1'b1;
			else if (ceo_last)
				valid_out <= 1'b0;		// drops the clock after the last ceo
			case (state)
				OUT_IDLE:
				begin
					if (rd.start)
					begin
						state   <= OUT_STREAM;
						pace    <= '0;
						rd_addr <= '0;
					end
				end
				OUT_STREAM:
				begin
					pace <= pace + 1'b1;	// wraps every 8
					if (rd.re)
					begin
						rd_addr <= rd_addr + 1'b1;
						if (rd_addr == blk_addr_t'(RS_K - 1))
							state <= OUT_IDLE;	// last read issued
					end
				end
				default: state <= OUT_IDLE;
			endcase
		end
	end

	// output byte register
	always_ff @(posedge clk)
	begin
		if (ld)
			out_byte <= rd.data;
	end

endmodule

// ==== design/rs_bus_if.sv ====
// rs_bus_if: write and read paths between the transport, the output banks and the out stage
`timescale 1ns/1ps

////////////////////////////////////////
// transport -> output banks
interface ram_wr_if
	import rs_pkg::*;
();
	logic      we;			// write one data byte
	blk_addr_t addr;		// byte position in bank
	gf_elem_t  data;		// data byte, or block_ok in bit 0 on block_done
	logic      block_done;	// one clock after the last write

	modport xfer (
		output we, addr, data, block_done
	);

	modport buffer (
		input we, addr, data, block_done
	);
endinterface

////////////////////////////////////////
// output banks -> out stage
interface ram_rd_if
	import rs_pkg::*;
();
	logic      start;		// full bank ready, one clock
	logic      re;			// read the drain bank
	blk_addr_t addr;
	gf_elem_t  data;		// follows re by one clock
	logic      block_ok;	// syndrome flag of the drain bank

	modport buffer (
		output start, data, block_ok,
		input  re, addr
	);

	modport reader (
		input  start, data, block_ok,
		output re, addr
	);
endinterface

// ==== design/rs_check_top.sv ====
// rs_check_top: RS(204,188) block checker, syndrome check and paced output of the data bytes
`timescale 1ns/1ps

module rs_check_top
	import rs_pkg::*;
(
	input  logic     clk,
	input  logic     reset,		// async, active high
	input  logic     ce,		// one clock per input byte, >= 8 clocks apart
	input  gf_elem_t in_byte,
	output gf_elem_t out_byte,
	output logic     ceo,		// one clock per output byte
	output logic     valid_out,	// output block window
	output logic     block_ok	// all 16 syndromes were zero
);

	////////////////////////////////////////
	// internal wiring
	logic      in_rd_re;
	blk_addr_t in_rd_addr;
	gf_elem_t  in_rd_data;
	logic      syn_ready;
	logic      syn_zero;
	logic      reader_busy;

	ram_wr_if wr_bus ();	// transport -> banks
	ram_rd_if rd_bus ();	// banks -> out stage

	// input memory and syndromes
	input_syndromes u_input_syndromes (
		.clk       (clk),
		.reset     (reset),
		.ce        (ce),
		.in_byte   (in_byte),
		.rd_re     (in_rd_re),
		.rd_addr   (in_rd_addr),
		.rd_data   (in_rd_data),
		.syn_ready (syn_ready),
		.syn_zero  (syn_zero)
	);

	// copy data bytes to the fill bank
	block_transport u_block_transport (
		.clk       (clk),
		.reset     (reset),
		.syn_ready (syn_ready),
		.syn_zero  (syn_zero),
		.rd_re     (in_rd_re),
		.rd_addr   (in_rd_addr),
		.rd_data   (in_rd_data),
		.wr        (wr_bus.xfer)
	);

	// ping-pong banks
	out_buffer u_out_buffer (
		.clk         (clk),
		.reset       (reset),
		.wr          (wr_bus.buffer),
		.rd          (rd_bus.buffer),
		.reader_busy (reader_busy)
	);

	// paced output
	out_stage u_out_stage (
		.clk       (clk),
		.reset     (reset),
		.rd        (rd_bus.reader),
		.busy      (reader_busy),
		.out_byte  (out_byte),
		.ceo       (ceo),
		.valid_out (valid_out),
		.block_ok  (block_ok)
	);

endmodule

// ==== design/rs_pkg.sv ====
// rs_pkg: shared constants, field types and control enums for the RS(204,188) block checker
package rs_pkg;

	////////////////////////////////////////
	// field and block types
	typedef logic [7:0] gf_elem_t;	// one GF(256) element / code byte
	typedef logic [7:0] blk_addr_t;	// byte index inside a block, 0..203
	typedef logic [3:0] syn_idx_t;	// syndrome index 0..15
	typedef logic [2:0] pace_cnt_t;	// output pacing counter

	////////////////////////////////////////
	// code constants
	localparam int RS_N        = 204;	// block length
	localparam int RS_K        = 188;	// data bytes
	localparam int RS_PARITY   = 16;	// parity bytes = number of syndromes
	localparam int OUT_SPACING = 8;		// clocks between ceo strobes

	// x^8+x^4+x^3+x^2+1, the x^8 term folds back into these bits
	localparam gf_elem_t GF_POLY_LOW = 8'h1d;

	////////////////////////////////////////
	// control state machines
	typedef enum logic {
		XFER_IDLE,
		XFER_COPY
	} xfer_state_t;

	typedef enum logic {
		OUT_IDLE,
		OUT_STREAM
	} out_state_t;

	// a * alpha^pw, unrolled shift and reduce
	// pw is a constant at every call so this folds into plain xor gates
	function automatic gf_elem_t gf_mul_alpha_pow(gf_elem_t a, syn_idx_t pw);
		gf_elem_t r;
		r = a;
		for (int k = 0; k < RS_PARITY; k++)
		begin
			if (k < int'(pw))
			begin
				r = {r[6:0], 1'b0} ^ (r[7] ? GF_POLY_LOW : gf_elem_t'(0));	// times alpha
			end
		end
		return r;
	endfunction

endpackage

// ==== verif/rs_ref_model.svh ====
// rs_ref_model: GF(256) arithmetic, RS(204,188) encoder, error injection and syndrome check
`ifndef RS_REF_MODEL_SVH
`define RS_REF_MODEL_SVH

gf_elem_t gen_poly [RS_PARITY+1];	// generator, gen_poly[16] is the x^16 term
gf_elem_t cw [RS_N];				// block under test, cw[0] is the x^203 term

// shift and add multiply, reduced by x^8+x^4+x^3+x^2+1
function automatic gf_elem_t gf_mult(gf_elem_t a, gf_elem_t b);
	gf_elem_t p;
	gf_elem_t x;
	p = '0;
	x = a;
	for (int k = 0; k < 8; k++)
	begin
		if (b[k])
			p = p ^ x;
		x = x[7] ? ((x << 1) ^ 8'h1d) : (x << 1);	// times x, fold the x^8 term
	end
	return p;
endfunction

// g(x) = (x + alpha^0)(x + alpha^1) ... (x + alpha^15)
function automatic void build_generator();
	gf_elem_t root;
	root = 8'h01;
	for (int j = 0; j <= RS_PARITY; j++)
		gen_poly[j] = '0;
	gen_poly[0] = 8'h01;
	for (int i = 0; i < RS_PARITY; i++)
	begin
		for (int j = RS_PARITY; j > 0; j--)
			gen_poly[j] = gen_poly[j-1] ^ gf_mult(gen_poly[j], root);
		gen_poly[0] = gf_mult(gen_poly[0], root);
		root        = gf_mult(root, 8'h02);	// next power of alpha
	end
endfunction

// systematic encode, message in cw[0..187], parity lands in cw[188..203]
function automatic void encode_block();
	gf_elem_t par [RS_PARITY];
	gf_elem_t fb;
	for (int j = 0; j < RS_PARITY; j++)
		par[j] = '0;
	for (int n = 0; n < RS_K; n++)
	begin
		fb = cw[n] ^ par[RS_PARITY-1];	// lfsr division by g(x)
		for (int j = RS_PARITY - 1; j > 0; j--)
			par[j] = par[j-1] ^ gf_mult(fb, gen_poly[j]);
		par[0] = gf_mult(fb, gen_poly[0]);
	end
	for (int j = 0; j < RS_PARITY; j++)
		cw[RS_K+j] = par[RS_PARITY-1-j];	// highest remainder term first
endfunction

// flip nerr distinct bytes anywhere in the block with nonzero patterns
function automatic void inject_errors(int nerr);
	bit hit [RS_N];
	int pos;
	for (int n = 0; n < RS_N; n++)
		hit[n] = 1'b0;
	for (int e = 0; e < nerr; e++)
	begin
		pos = $unsigned($random(seed)) % RS_N;
		while (hit[pos])
			pos = $unsigned($random(seed)) % RS_N;
		hit[pos] = 1'b1;
		cw[pos]  = cw[pos] ^ gf_elem_t'(1 + $unsigned($random(seed)) % 255);
	end
endfunction

// r(alpha^i) for i = 0..15, block is good when every one is zero
function automatic logic syndromes_zero();
	gf_elem_t root;
	gf_elem_t s;
	logic     ok;
	ok   = 1'b1;
	root = 8'h01;
	for (int i = 0; i < RS_PARITY; i++)
	begin
		s = '0;
		for (int n = 0; n < RS_N; n++)
			s = gf_mult(s, root) ^ cw[n];	// horner, first byte highest power
		if (s != '0)
			ok = 1'b0;
		root = gf_mult(root, 8'h02);
	end
	return ok;
endfunction

`endif

// ==== verif/tb_rs_check.sv ====
// tb_rs_check: random RS(204,188) blocks through the checker, bytes and flags against a model
`timescale 1ns/1ps

module tb_rs_check
	import rs_pkg::*;
();

	localparam int NUM_BLOCKS    = 20;
	localparam int MIN_GAP       = 8;		// minimum input ce spacing
	localparam int FAST_BLOCKS   = 6;		// first blocks back to back at MIN_GAP
	localparam int DRAIN_TIMEOUT = 5000;	// clocks allowed to empty the pipe
	localparam int QUIET_CLOCKS  = 4 * OUT_SPACING;	// a repeated block would start in here

	logic     clk;
	logic     reset;
	logic     ce;
	gf_elem_t in_byte;
	gf_elem_t out_byte;
	logic     ceo;
	logic     valid_out;
	logic     block_ok;

	integer   seed;
	gf_elem_t exp_bytes [$];	// data bytes still due at the output
	logic     exp_flags [$];	// one block_ok per block still due
	logic     first_in;		// a full block has entered

	`include "rs_ref_model.svh"

	rs_check_top UUT (
		.clk       (clk),
		.reset     (reset),
		.ce        (ce),
		.in_byte   (in_byte),
		.out_byte  (out_byte),
		.ceo       (ceo),
		.valid_out (valid_out),
		.block_ok  (block_ok)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;	// 8 ns
	end

	////////////////////////////////////////
	// failure reporting and compares
	task automatic stop_with_failure();
		$display("Some tests failed");
		$fatal(1);
	endtask

	task automatic abort_run(string msg);
		$display("ERROR at %0t ns: %s", $time, msg);
		stop_with_failure();
	endtask

	task automatic check_byte(gf_elem_t got, gf_elem_t exp, string what);
		if (got !== exp)
		begin
			$display("FAIL at %0t ns: %s got %02h expected %02h", $time, what, got, exp);
			stop_with_failure();
		end
	endtask

	task automatic check_flag(logic got, logic exp, string what);
		if (got !== exp)
		begin
			$display("FAIL at %0t ns: %s got %b expected %b", $time, what, got, exp);
			stop_with_failure();
		end
	endtask

	task automatic check_count(blk_addr_t got, blk_addr_t exp, string what);
		if (got !== exp)
		begin
			$display("FAIL at %0t ns: %s got %0d expected %0d", $time, what, got, exp);
			stop_with_failure();
		end
	endtask

	// one strobed byte, next one may follow gap clocks later
	task automatic send_byte(gf_elem_t b, int gap);
		@(posedge clk);
		#1;
		ce      = 1'b1;
		in_byte = b;
		@(posedge clk);
		#1;
		ce = 1'b0;
		repeat (gap - 2) @(posedge clk);
	endtask

	////////////////////////////////////////
	// stimulus
	initial
	begin
		int   gap;
		int   nerr;
		int   timeout;
		logic corrupt;
		logic ok;
		seed     = 32'h2fbd35d6;
		reset    = 1'b1;
		ce       = 1'b0;
		in_byte  = '0;
		first_in = 1'b0;
		build_generator();
		repeat (10) @(posedge clk);
		#1 reset = 1'b0;
		for (int b = 0; b < NUM_BLOCKS; b++)
		begin
			for (int n = 0; n < RS_K; n++)
				cw[n] = gf_elem_t'($random(seed));	// random message
			encode_block();
			check_flag(syndromes_zero(), 1'b1, "model syndromes of a clean codeword");
			corrupt = (b == 1) || ((b > 2) && (($random(seed) & 1) != 0));	// 0 and 2 stay clean
			if (corrupt)
			begin
				nerr = 1 + $unsigned($random(seed)) % 8;
				inject_errors(nerr);
			end
			ok = syndromes_zero();
			check_flag(ok, !corrupt, "model flag after error injection");
			for (int n = 0; n < RS_K; n++)
				exp_bytes.push_back(cw[n]);		// received data, no correction
			exp_flags.push_back(ok);
			for (int n = 0; n < RS_N; n++)
			begin
				gap = (b < FAST_BLOCKS) ? MIN_GAP : MIN_GAP + $unsigned($random(seed)) % 13;
				send_byte(cw[n], gap);
			end
			first_in = 1'b1;
		end
		timeout = 0;
		while ((exp_flags.size() != 0) && (timeout < DRAIN_TIMEOUT))
		begin
			@(posedge clk);
			timeout++;
		end
		if (exp_flags.size() != 0)
			abort_run("timeout, not all blocks came out of the checker");
		else
		begin
			repeat (QUIET_CLOCKS) @(posedge clk);	// monitor flags any extra output here
			$display("All tests passed");
			$finish;
		end
	end

	////////////////////////////////////////
	// output monitor, samples on the falling edge
	initial
	begin
		int       since_ceo;
		int       win_count;
		logic     prev_valid;
		gf_elem_t exp_b;
		since_ceo   = 0;
		win_count   = 0;
		prev_valid  = 1'b0;
		forever
		begin
			@(negedge clk);
			since_ceo++;
			if (!first_in)
			begin
				check_flag(ceo, 1'b0, "ceo before a full block entered");
				check_flag(valid_out, 1'b0, "valid_out before a full block entered");
			end
			if (valid_out && !prev_valid)
				win_count = 0;	// new block window
			if (valid_out)
			begin
				if (exp_flags.size() == 0)
					abort_run("output block seen with no block expected");
				else
					check_flag(block_ok, exp_flags[0], "block_ok inside window");
			end
			if (ceo)
			begin
				check_flag(valid_out, 1'b1, "valid_out with ceo");
				if (win_count > 0)
					check_count(blk_addr_t'(since_ceo), blk_addr_t'(OUT_SPACING),
						"clocks between ceo");
				if (exp_bytes.size() == 0)
					abort_run("output byte seen with no byte expected");
				else
				begin
					exp_b = exp_bytes.pop_front();
					check_byte(out_byte, exp_b, "output byte");
				end
				since_ceo = 0;
				win_count++;
			end
			if (prev_valid && !valid_out)
			begin
				check_count(blk_addr_t'(win_count), blk_addr_t'(RS_K), "ceo pulses in window");
				check_count(blk_addr_t'(since_ceo), blk_addr_t'(1), "last ceo to valid_out fall");
				void'(exp_flags.pop_front());	// block done
			end
			prev_valid = valid_out;
		end
	end

endmodule
